// ==== frame_buffer_top.f ====
+incdir+src
src/fb_pkg.sv
src/credit_queue.sv
src/fb_writer.sv
src/fb_memory.sv
src/fb_reader.sv
src/frame_buffer_top.sv
tb/tb_frame_buffer.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the frame buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_frame_buffer \
	-f frame_buffer_top.f \
	-o sim_frame_buffer
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/sim_frame_buffer)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qxF '>>> PASS'; then
	exit 0
fi
exit 1

// ==== src/credit_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module credit_queue #(
	parameter type T = logic [7:0],
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic rst_n,
	input logic push,
	input T push_data,
	input logic pop,
	output logic head_valid,
	output T head_data,
	output logic credit
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	T store [DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] count;
	logic full;
	logic do_pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full = (count == CNT_W'(DEPTH));
	assign head_valid = (count != '0);
	assign head_data = store[rd_ptr];
	// a pop on an empty queue is ignored
	assign do_pop = pop & head_valid;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			// slot handed back to the sender one cycle after release
			credit <= do_pop;
			case ({push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			store[wr_ptr] <= push_data;
	end

	// sender overran the credits it was given
	a_push_not_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
		else $error("credit_queue: push while full");

	a_pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> head_valid)
		else $error("credit_queue: pop while empty");

endmodule

`default_nettype wire

// ==== src/fb_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fb_settings.svh"

module fb_memory (
	input logic clk,
	input logic rst_n,
	input logic rd_req,
	input fb_pkg::word_addr_t rd_addr,
	output logic [15:0] rd_data,
	input logic wr_req,
	input fb_pkg::mem_wr_t wr,
	output logic wr_grant
);

	logic [15:0] mem [`FB_WORDS];

	// scan-out never waits, writes take the gaps
	assign wr_grant = wr_req & ~rd_req;

	always_ff @(posedge clk) begin
		if (rd_req)
			rd_data <= mem[rd_addr];
	end

	// per-lane enables so a half-pixel leaves its neighbour alone
	always_ff @(posedge clk) begin
		if (wr_grant) begin
			if (wr.ub)
				mem[wr.addr][15:8] <= wr.data[15:8];
			if (wr.lb)
				mem[wr.addr][7:0] <= wr.data[7:0];
		end
	end

	a_rd_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
		rd_req |-> rd_addr < `FB_WORDS)
		else $error("fb_memory: read address %0d out of range", rd_addr);

	a_wr_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
		wr_req |-> wr.addr < `FB_WORDS)
		else $error("fb_memory: write address %0d out of range", wr.addr);

endmodule

`default_nettype wire

// ==== src/fb_pkg.sv ====
`default_nettype none

`include "fb_settings.svh"

package fb_pkg;

	// msb holds the first byte in memory
	typedef logic [23:0] color_t;

	// ray id doubles as the pixel index
	typedef logic [`RAY_ID_W-1:0] ray_id_t;

	typedef logic [`FB_ADDR_W-1:0] word_addr_t;
	typedef logic [15:0] word_t;

	typedef struct packed {
		ray_id_t ray_id;
		color_t color;
	} pixel_entry_t;

	// one half-pixel write, ub covers data[15:8], lb covers data[7:0]
	typedef struct packed {
		word_addr_t addr;
		word_t data;
		logic ub;
		logic lb;
	} mem_wr_t;

	typedef struct packed {
		color_t color;
		logic last;
	} disp_pixel_t;

endpackage

`default_nettype wire

// ==== src/fb_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fb_settings.svh"

module fb_reader (
	input logic clk,
	input logic rst_n,
	input logic scan_en,
	output logic rd_req,
	output fb_pkg::word_addr_t rd_addr,
	input logic [15:0] rd_data,
	output logic disp_valid,
	output fb_pkg::disp_pixel_t disp,
	input logic disp_credit
);

	localparam int AW = $bits(fb_pkg::word_addr_t);
	localparam int CNT_W = AW + 1;
	localparam int SLOT_W = $clog2(`OUT_DEPTH + 1);
	localparam int CRED_W = 12;

	logic scanning;
	logic [CNT_W-1:0] word_cnt;
	logic [2:0] rd_phase;
	logic [2:0] cap_phase;
	logic push2;
	logic grp_start;
	logic [15:0] a_q, b_q, c_q;
	logic [SLOT_W-1:0] free_slots;
	logic [CRED_W-1:0] disp_credits;

	logic q_push;
	fb_pkg::disp_pixel_t q_push_data;
	logic q_head_valid;
	fb_pkg::disp_pixel_t q_head;
	logic q_credit;
	logic send;

	assign rd_req = |rd_phase;
	assign rd_addr = word_cnt[AW-1:0];

	// a group reserves both of its output slots up front
	assign grp_start = scanning && (rd_phase == 3'b000) &&
		(word_cnt < CNT_W'(`FB_WORDS)) && (free_slots >= SLOT_W'(2));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			scanning <= 1'b0;
			word_cnt <= '0;
			rd_phase <= 3'b000;
			cap_phase <= 3'b000;
			push2 <= 1'b0;
		end else begin
			if (!scanning) begin
				if (scan_en) begin
					scanning <= 1'b1;
					word_cnt <= '0;
				end
			end else if (send && q_head.last) begin
				scanning <= 1'b0;
			end
			if (rd_req)
				word_cnt <= word_cnt + 1'b1;
			// phases a, b, c then idle
			rd_phase <= grp_start ? 3'b100 : {1'b0, rd_phase[2:1]};
			// read data lands one cycle behind the phase
			cap_phase <= rd_phase;
			push2 <= cap_phase[0];
		end
	end

	always_ff @(posedge clk) begin
		if (cap_phase[2])
			a_q <= rd_data;
		if (cap_phase[1])
			b_q <= rd_data;
		if (cap_phase[0])
			c_q <= rd_data;
	end

	// first pixel once c arrives, second one cycle later
	assign q_push = cap_phase[0] | push2;

	always_comb begin
		if (cap_phase[0]) begin
			q_push_data.color = {a_q, b_q[15:8]};
			q_push_data.last = 1'b0;
		end else begin
			q_push_data.color = {b_q[7:0], c_q};
			// next group cannot have read yet, so the count still marks this group
			q_push_data.last = (word_cnt == CNT_W'(`FB_WORDS));
		end
	end

	credit_queue #(
		.T(fb_pkg::disp_pixel_t),
		.DEPTH(`OUT_DEPTH)
	) out_queue (
		.clk(clk),
		.rst_n(rst_n),
		.push(q_push),
		.push_data(q_push_data),
		.pop(send),
		.head_valid(q_head_valid),
		.head_data(q_head),
		.credit(q_credit)
	);

	// spend one display credit per pixel
	assign send = q_head_valid && (disp_credits != '0);
	assign disp_valid = send;
	assign disp = q_head;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			free_slots <= SLOT_W'(`OUT_DEPTH);
			disp_credits <= '0;
		end else begin
			free_slots <= free_slots - (grp_start ? SLOT_W'(2) : SLOT_W'(0)) +
				SLOT_W'(q_credit);
			disp_credits <= disp_credits + CRED_W'(disp_credit) - CRED_W'(send);
		end
	end

endmodule

`default_nettype wire

// ==== src/fb_settings.svh ====
`ifndef FB_SETTINGS_SVH
`define FB_SETTINGS_SVH

// frame geometry in pixels
`define FB_WIDTH 4
`define FB_HEIGHT 4
// pixel count, must be even so that pixels pair up in three words
`define FB_PIXELS (`FB_WIDTH * `FB_HEIGHT)

// three bytes per pixel in 16-bit words
`define FB_WORDS ((`FB_PIXELS * 3) / 2)
`define FB_ADDR_W 5

`define RAY_ID_W 8

// input queue depth, also the renderer's starting credits
`define PB_DEPTH 4
// scan-out queue depth
`define OUT_DEPTH 4

`endif

// ==== src/fb_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fb_writer (
	input logic clk,
	input logic rst_n,
	input logic entry_valid,
	input fb_pkg::pixel_entry_t entry,
	output logic entry_pop,
	output logic wr_req,
	output fb_pkg::mem_wr_t wr,
	input logic wr_grant
);

	logic second;
	logic odd;
	logic fire;
	fb_pkg::color_t color;
	fb_pkg::word_addr_t addr0;
	fb_pkg::word_addr_t addr1;
	fb_pkg::word_t first_data;
	fb_pkg::word_t second_data;

	assign color = entry.color;
	assign odd = entry.ray_id[0];

	// word p + floor(p/2) holds the start of pixel p
	assign addr0 = fb_pkg::word_addr_t'(entry.ray_id) +
		fb_pkg::word_addr_t'(entry.ray_id >> 1);
	assign addr1 = addr0 + 1'b1;

	// odd pixels start in the lower lane, even ones end in the upper lane
	assign first_data = odd ? {2{color[23:16]}} : color[23:8];
	assign second_data = odd ? color[15:0] : {2{color[7:0]}};

	assign wr_req = entry_valid;
	assign fire = wr_req & wr_grant;
	assign entry_pop = fire & second;

	always_comb begin
		if (!second) begin
			wr.addr = addr0;
			wr.data = first_data;
			wr.ub = ~odd;
			wr.lb = 1'b1;
		end else begin
			wr.addr = addr1;
			wr.data = second_data;
			wr.ub = 1'b1;
			wr.lb = odd;
		end
	end

	// toggles on every granted half-write
	always_ff @(posedge clk) begin
		if (!rst_n)
			second <= 1'b0;
		else if (fire)
			second <= ~second;
	end

	// a stalled write must not change under the memory
	a_wr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		wr_req && !wr_grant |=> wr_req && $stable(wr))
		else $error("fb_writer: write changed while waiting for grant");

endmodule

`default_nettype wire

// ==== src/frame_buffer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fb_settings.svh"

module frame_buffer_top (
	input logic clk,
	input logic rst_n,
	input logic pix_valid,
	input fb_pkg::pixel_entry_t pix,
	output logic pix_credit,
	input logic scan_en,
	output logic disp_valid,
	output fb_pkg::disp_pixel_t disp,
	input logic disp_credit
);

	logic entry_valid;
	fb_pkg::pixel_entry_t entry;
	logic entry_pop;

	logic wr_req;
	fb_pkg::mem_wr_t wr;
	logic wr_grant;

	logic rd_req;
	fb_pkg::word_addr_t rd_addr;
	logic [15:0] rd_data;

	// renderer credits come straight back from the input queue
	credit_queue #(
		.T(fb_pkg::pixel_entry_t),
		.DEPTH(`PB_DEPTH)
	) pix_queue (
		.clk(clk),
		.rst_n(rst_n),
		.push(pix_valid),
		.push_data(pix),
		.pop(entry_pop),
		.head_valid(entry_valid),
		.head_data(entry),
		.credit(pix_credit)
	);

	fb_writer writer (
		.clk(clk),
		.rst_n(rst_n),
		.entry_valid(entry_valid),
		.entry(entry),
		.entry_pop(entry_pop),
		.wr_req(wr_req),
		.wr(wr),
		.wr_grant(wr_grant)
	);

	fb_memory memory (
		.clk(clk),
		.rst_n(rst_n),
		.rd_req(rd_req),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.wr_req(wr_req),
		.wr(wr),
		.wr_grant(wr_grant)
	);

	fb_reader reader (
		.clk(clk),
		.rst_n(rst_n),
		.scan_en(scan_en),
		.rd_req(rd_req),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.disp_valid(disp_valid),
		.disp(disp),
		.disp_credit(disp_credit)
	);

endmodule

`default_nettype wire

// ==== tb/fb_tests.txt ====
// one 40-bit record per line: op (2 digits), ray id (2), color (6)
// op 01 write pixel, 02 scan (id is the credit gap mask), 03 expected color, ff end
// first frame in shuffled order
0107A757C7
0102A252C2
010CAC5CCC
0100A050C0
010FAF5FCF
0105A555C5
0109A959C9
0103A353C3
010EAE5ECE
0101A151C1
010AAA5ACA
0106A656C6
010DAD5DCD
0108A858C8
0104A454C4
010BAB5BCB
0203000000
0300A050C0
0301A151C1
0302A252C2
0303A353C3
0304A454C4
0305A555C5
0306A656C6
0307A757C7
0308A858C8
0309A959C9
030AAA5ACA
030BAB5BCB
030CAC5CCC
030DAD5DCD
030EAE5ECE
030FAF5FCF
// rewrite two odd and two even pixels, then scan with long credit gaps
0105123456
0106789ABC
010ADEF012
010D3C5A69
021F000000
0300A050C0
0301A151C1
0302A252C2
0303A353C3
0304A454C4
0305123456
0306789ABC
0307A757C7
0308A858C8
0309A959C9
030ADEF012
030BAB5BCB
030CAC5CCC
030D3C5A69
030EAE5ECE
030FAF5FCF
FF00000000

// ==== tb/tb_frame_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fb_settings.svh"

module tb_frame_buffer;

	localparam int MAX_RECS = 128;
	localparam logic [7:0] OP_WRITE = 8'h01;
	localparam logic [7:0] OP_SCAN = 8'h02;
	localparam logic [7:0] OP_EXPECT = 8'h03;
	localparam logic [7:0] OP_END = 8'hff;

	logic clk;
	logic rst_n;
	logic pix_valid;
	fb_pkg::pixel_entry_t pix;
	logic pix_credit;
	logic scan_en;
	logic disp_valid;
	fb_pkg::disp_pixel_t disp;
	logic disp_credit;

	// op, ray id, color
	logic [39:0] recs [0:MAX_RECS-1];

	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int cycle_limit = 0;
	int sent = 0;
	int returned = 0;
	int disp_held = 0;
	int grants_left = 0;
	int gap_left = 0;
	logic [31:0] gap_mask = 32'd0;
	logic [31:0] rng = 32'd26205;
	fb_pkg::disp_pixel_t got_q[$];

	frame_buffer_top UUT (
		.clk(clk),
		.rst_n(rst_n),
		.pix_valid(pix_valid),
		.pix(pix),
		.pix_credit(pix_credit),
		.scan_en(scan_en),
		.disp_valid(disp_valid),
		.disp(disp),
		.disp_credit(disp_credit)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic expect_equal(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// renderer side, spends one credit per pixel
	task automatic send_pixel(input logic [7:0] id, input logic [23:0] color);
		while (sent - returned >= `PB_DEPTH)
			next_cycle();
		pix_valid = 1'b1;
		pix.ray_id = id;
		pix.color = color;
		sent++;
		next_cycle();
		pix_valid = 1'b0;
	endtask

	task automatic wait_credits_home();
		while (returned != sent)
			next_cycle();
	endtask

	task automatic run_scan(input int at);
		int k;
		logic [39:0] rec;
		fb_pkg::disp_pixel_t px;
		// all writes have landed once every credit is back
		wait_credits_home();
		expect_equal("pixels before scan", 32'(got_q.size()), 32'd0);
		gap_mask = 32'(recs[at][31:24]);
		grants_left = `FB_PIXELS;
		scan_en = 1'b1;
		next_cycle();
		scan_en = 1'b0;
		while (got_q.size() < `FB_PIXELS)
			next_cycle();
		for (k = 0; k < `FB_PIXELS; k++) begin
			rec = recs[at + 1 + k];
			px = got_q.pop_front();
			if (rec[39:32] != OP_EXPECT) begin
				errors++;
				$display("record %0d should hold an expected color", at + 1 + k);
			end
			expect_equal($sformatf("disp.color[%0d]", k), 32'(px.color), 32'(rec[23:0]));
			expect_equal($sformatf("disp.last[%0d]", k), 32'(px.last),
				32'(k == `FB_PIXELS - 1));
		end
	endtask

	// display model, one credit per pixel at random gaps
	always begin
		@(posedge clk);
		#1;
		disp_credit = 1'b0;
		if (grants_left > 0) begin
			if (gap_left == 0) begin
				disp_credit = 1'b1;
				grants_left--;
				rng = xorshift32(rng);
				gap_left = int'(rng & gap_mask);
			end else begin
				gap_left--;
			end
		end
	end

	// sampled before the edge updates anything
	always @(posedge clk) begin
		if (rst_n) begin
			if (pix_credit) begin
				if (returned >= sent) begin
					errors++;
					$display("pix_credit came back with no pixel outstanding");
				end
				returned++;
			end
			if (disp_valid) begin
				if (disp_held <= 0) begin
					errors++;
					$display("disp_valid raised with no display credit in hand");
				end
				got_q.push_back(disp);
			end
			disp_held = disp_held + int'(disp_credit) - int'(disp_valid);
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, %0d errors so far", cycles, errors);
			$display(">>> FAIL");
			$finish;
		end
	end

	initial begin
		int n;
		int idx;
		logic [7:0] op;
		rst_n = 1'b0;
		pix_valid = 1'b0;
		pix = '0;
		scan_en = 1'b0;
		disp_credit = 1'b0;
		$readmemh("tb/fb_tests.txt", recs);
		n = 0;
		while (n < MAX_RECS && recs[n][39:32] !== OP_END)
			n++;
		if (n == MAX_RECS) begin
			errors++;
			$display("data file has no end record");
		end
		cycle_limit = (n + 1) * 40;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// quiet after reset
		repeat (8) begin
			next_cycle();
			expect_equal("disp_valid", 32'(disp_valid), 32'd0);
		end
		expect_equal("pix_credit count", 32'(returned), 32'd0);

		idx = 0;
		while (idx < n) begin
			op = recs[idx][39:32];
			if (op == OP_WRITE) begin
				send_pixel(recs[idx][31:24], recs[idx][23:0]);
				idx++;
			end else if (op == OP_SCAN && idx + `FB_PIXELS < n) begin
				run_scan(idx);
				idx = idx + 1 + `FB_PIXELS;
			end else begin
				errors++;
				$display("record %0d has an unknown op or a short scan", idx);
				idx++;
			end
		end

		wait_credits_home();
		repeat (20) next_cycle();
		expect_equal("pix_credit total", 32'(returned), 32'(sent));
		expect_equal("extra scan pixels", 32'(got_q.size()), 32'd0);
		expect_equal("display credits left", 32'(disp_held), 32'd0);

		$display("run finished: %0d errors in %0d checks", errors, checks);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire
